/* mem_addressing.f */
+incdir+verilog
verilog/mem_map_pkg.sv
verilog/mem_access_if.sv
verilog/memory_addressing.sv
verilog/data_ram.sv
verilog/io_port_bank.sv
verilog/read_return.sv
verilog/mem_subsystem.sv
sim/tb_mem_subsystem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_mem_subsystem
FILELIST = mem_addressing.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the verdict comes from the log, so a crash without the pass line also fails.
run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/tb_mem_subsystem.sv */
//********************
// RAM is filled through the write port before any read, since it has no reset.
// outputs are sampled 1 ns after the rising edge.
//********************
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsystem;

    localparam int CLOCK_PERIOD    = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int RAM_WORDS       = 1 << `RAM_OFFSET_WIDTH;
    localparam int DIRECTED_CYCLES = 23;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TEST_CYCLES     = RESET_CYCLES + RAM_WORDS + DIRECTED_CYCLES + RANDOM_CYCLES;

    logic                   clock;
    logic                   rst;
    logic                   ior;
    logic                   cancel;
    mem_map_pkg::addr_t     read_addr;
    logic                   ior_previous;
    logic                   cancel_previous;
    mem_map_pkg::addr_t     write_addr;
    mem_map_pkg::data_t     write_data;
    mem_map_pkg::data_t     read_data;
    logic                   read_valid;
    mem_map_pkg::io_words_t io_in;
    mem_map_pkg::io_words_t io_out;

    // reference state, updated once per driven cycle.
    mem_map_pkg::data_t     ram_model [RAM_WORDS];
    mem_map_pkg::io_words_t io_out_model;
    mem_map_pkg::io_words_t io_in_seen;
    mem_map_pkg::io_words_t io_stimulus;
    logic [31:0]            lfsr_state;

    // one entry per driven cycle, consumed after the edge that ends it.
    logic                   expected_valid_q [$];
    mem_map_pkg::data_t     expected_data_q [$];
    mem_map_pkg::io_words_t expected_io_out_q [$];
    logic                   want_valid;
    mem_map_pkg::data_t     want_data;
    mem_map_pkg::io_words_t want_io_out;
    int                     error_count;
    int                     check_count;

    mem_subsystem u_mem_subsystem (
        .clock           (clock),
        .rst             (rst),
        .ior             (ior),
        .cancel          (cancel),
        .read_addr       (read_addr),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .read_data       (read_data),
        .read_valid      (read_valid),
        .io_in           (io_in),
        .io_out          (io_out)
    );

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken.
    function automatic logic [31:0] take_random(input int count);
        logic [31:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    // true with a chance of one in 2**count.
    function automatic logic random_all_ones(input int count);
        logic [31:0] bits;
        bits = take_random(count);
        return bits == ((32'd1 << count) - 32'd1);
    endfunction

    // addresses lean towards the mapped ranges so that most accesses hit.
    function automatic mem_map_pkg::addr_t random_addr();
        logic [31:0] pick;
        logic [31:0] low;
        pick = take_random(2);
        case (pick[1:0])
            2'd0: begin
                low = take_random(8);
                return `RAM_BASE | {2'b00, low[7:0]};
            end
            2'd1: begin
                low = take_random(3);
                return `IO_IN_BASE | {7'b0, low[2:0]};
            end
            2'd2: begin
                low = take_random(3);
                return `IO_OUT_BASE | {7'b0, low[2:0]};
            end
            default: begin
                low = take_random(10);
                return low[9:0];
            end
        endcase
    endfunction

    function automatic mem_map_pkg::io_words_t random_io_words();
        return {take_random(32), take_random(32), take_random(32), take_random(32),
                take_random(32), take_random(32), take_random(32), take_random(32)};
    endfunction

    // every bit of the address shows up in the word.
    function automatic mem_map_pkg::data_t fill_word(input mem_map_pkg::addr_t a);
        return {a, 6'h2b, ~a, a[5:0]};
    endfunction

    // returns {valid, data} seen one cycle later, and applies this cycle's writes.
    function automatic logic [32:0] reference_step(
        input logic                   reset_now,
        input logic                   r_issue,
        input logic                   r_cancel,
        input mem_map_pkg::addr_t     r_addr,
        input logic                   w_issue,
        input logic                   w_cancel,
        input mem_map_pkg::addr_t     w_addr,
        input mem_map_pkg::data_t     w_data,
        input mem_map_pkg::io_words_t io_now
    );
        mem_map_pkg::addr_t offset;
        logic [32:0]        result;
        result = '0;
        // reads see the RAM before this cycle's write, and io_in from one cycle back.
        if (!reset_now && r_issue && !r_cancel) begin
            if (r_addr >= `RAM_BASE && r_addr <= `RAM_BOUND) begin
                offset = r_addr - `RAM_BASE;
                result = {1'b1, ram_model[mem_map_pkg::ram_offset_t'(offset)]};
            end else if (r_addr >= `IO_IN_BASE && r_addr <= `IO_IN_BOUND) begin
                offset = r_addr - `IO_IN_BASE;
                result = {1'b1, io_in_seen[mem_map_pkg::io_offset_t'(offset)]};
            end
        end
        if (reset_now) begin
            io_out_model = '0;
        end else if (w_issue && !w_cancel) begin
            if (w_addr >= `RAM_BASE && w_addr <= `RAM_BOUND) begin
                offset = w_addr - `RAM_BASE;
                ram_model[mem_map_pkg::ram_offset_t'(offset)] = w_data;
            end else if (w_addr >= `IO_OUT_BASE && w_addr <= `IO_OUT_BOUND) begin
                offset = w_addr - `IO_OUT_BASE;
                io_out_model[mem_map_pkg::io_offset_t'(offset)] = w_data;
            end
        end
        io_in_seen = io_now;
        return result;
    endfunction

    task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // drives one cycle on the falling edge and queues what it should produce.
    task automatic drive_cycle(
        input logic               reset_now,
        input logic               r_issue,
        input logic               r_cancel,
        input mem_map_pkg::addr_t r_addr,
        input logic               w_issue,
        input logic               w_cancel,
        input mem_map_pkg::addr_t w_addr,
        input mem_map_pkg::data_t w_data
    );
        logic [32:0] expected;
        @(negedge clock);
        rst             = reset_now;
        ior             = r_issue;
        cancel          = r_cancel;
        read_addr       = r_addr;
        ior_previous    = w_issue;
        cancel_previous = w_cancel;
        write_addr      = w_addr;
        write_data      = w_data;
        io_in           = io_stimulus;
        expected = reference_step(reset_now, r_issue, r_cancel, r_addr,
                                  w_issue, w_cancel, w_addr, w_data, io_stimulus);
        expected_valid_q.push_back(expected[32]);
        expected_data_q.push_back(expected[31:0]);
        expected_io_out_q.push_back(io_out_model);
    endtask

    // outputs are registered, so 1 ns after the edge they are settled.
    always @(posedge clock) begin
        #1;
        if (expected_valid_q.size() != 0) begin
            want_valid  = expected_valid_q.pop_front();
            want_data   = expected_data_q.pop_front();
            want_io_out = expected_io_out_q.pop_front();
            check_value(256'(read_valid), 256'(want_valid), "read_valid");
            check_value(256'(read_data), 256'(want_data), "read_data");
            check_value(io_out, want_io_out, "io_out");
        end
    end

    initial begin
        #((TEST_CYCLES + 100) * CLOCK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles.", TEST_CYCLES + 100);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        int                 i;
        logic               r_issue;
        logic               r_cancel;
        logic               w_issue;
        logic               w_cancel;
        mem_map_pkg::addr_t r_addr;
        mem_map_pkg::addr_t w_addr;
        mem_map_pkg::addr_t io_addr;
        mem_map_pkg::data_t w_data;
        lfsr_state      = 32'h27ce;
        error_count     = 0;
        check_count     = 0;
        io_out_model    = '0;
        io_in_seen      = '0;
        io_stimulus     = '0;
        rst             = 1'b1;
        ior             = 1'b0;
        cancel          = 1'b0;
        read_addr       = '0;
        ior_previous    = 1'b0;
        cancel_previous = 1'b0;
        write_addr      = '0;
        write_data      = '0;
        io_in           = '0;

        // reads and writes during reset must neither raise read_valid nor change io_out.
        for (i = 0; i < RESET_CYCLES; i++) begin
            drive_cycle(1'b1, 1'b1, 1'b0, 10'h005, 1'b1, 1'b0, 10'h20c, 32'hdead_beef);
        end

        // every RAM word gets a known value before the first read.
        for (i = 0; i < RAM_WORDS; i++) begin
            w_addr = `RAM_BASE + i[9:0];
            drive_cycle(1'b0, 1'b0, 1'b0, 10'h000, 1'b1, 1'b0, w_addr, fill_word(w_addr));
        end

        // write then read back, then a read and write of one word in the same cycle.
        drive_cycle(1'b0, 1'b0, 1'b0, 10'h000, 1'b1, 1'b0, 10'h012, 32'hcafe_0012);
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h012, 1'b0, 1'b0, 10'h000, 32'h0);
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h013, 1'b1, 1'b0, 10'h013, 32'hbeef_0013);
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h013, 1'b0, 1'b0, 10'h000, 32'h0);

        // accesses that are not issued or are cancelled on either side change nothing.
        // the last read shows that 0x020 kept its fill word.
        drive_cycle(1'b0, 1'b0, 1'b0, 10'h020, 1'b0, 1'b0, 10'h020, 32'h1111_1111);
        drive_cycle(1'b0, 1'b1, 1'b1, 10'h020, 1'b1, 1'b1, 10'h209, 32'h2222_2222);
        drive_cycle(1'b0, 1'b0, 1'b1, 10'h201, 1'b0, 1'b1, 10'h020, 32'h3333_3333);
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h020, 1'b0, 1'b0, 10'h000, 32'h0);

        // accesses outside every range do nothing, even in the I/O ranges used backwards.
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h20a, 1'b1, 1'b0, 10'h203, 32'h4444_4444);
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h150, 1'b1, 1'b0, 10'h300, 32'h5555_5555);
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h3ff, 1'b1, 1'b0, 10'h100, 32'h6666_6666);
        // the writes to 0x300 and 0x100 would land on RAM word 0 if the bound were ignored.
        drive_cycle(1'b0, 1'b1, 1'b0, 10'h000, 1'b0, 1'b0, 10'h000, 32'h0);

        // output writes at both ends of the range and in the middle.
        drive_cycle(1'b0, 1'b0, 1'b0, 10'h000, 1'b1, 1'b0, 10'h20b, 32'h7777_7777);
        drive_cycle(1'b0, 1'b0, 1'b0, 10'h000, 1'b1, 1'b0, 10'h208, 32'h8888_8888);
        drive_cycle(1'b0, 1'b0, 1'b0, 10'h000, 1'b1, 1'b0, 10'h20f, 32'h9999_9999);

        // io_in changes every cycle, so each read must see the older sample.
        for (io_addr = `IO_IN_BASE; io_addr <= `IO_IN_BOUND; io_addr++) begin
            io_stimulus = random_io_words();
            drive_cycle(1'b0, 1'b1, 1'b0, io_addr, 1'b0, 1'b0, 10'h000, 32'h0);
        end

        // back-to-back random traffic on both sides at once.
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            r_issue     = !random_all_ones(2);
            r_cancel    = random_all_ones(2);
            r_addr      = random_addr();
            w_issue     = !random_all_ones(2);
            w_cancel    = random_all_ones(2);
            w_addr      = random_addr();
            w_data      = take_random(32);
            io_stimulus = random_io_words();
            drive_cycle(1'b0, r_issue, r_cancel, r_addr, w_issue, w_cancel, w_addr, w_data);
        end

        while (expected_valid_q.size() != 0) begin
            @(negedge clock);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mem_subsystem.sv */
//********************
// reads return after one cycle with no stall; unmapped accesses do nothing.
// writes come from the previous instruction, reads from the current one.
//********************
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem (
    input wire clock,
    input wire rst,

    // read side, current instruction.
    input wire                     ior,
    input wire                     cancel,
    input wire mem_map_pkg::addr_t read_addr,

    // write side, previous instruction.
    input wire                     ior_previous,
    input wire                     cancel_previous,
    input wire mem_map_pkg::addr_t write_addr,
    input wire mem_map_pkg::data_t write_data,

    // read result.
    output mem_map_pkg::data_t read_data,
    output logic               read_valid,

    // external I/O words.
    input wire mem_map_pkg::io_words_t io_in,
    output mem_map_pkg::io_words_t     io_out
);

    mem_map_pkg::data_t ram_word;
    mem_map_pkg::data_t io_word;

    // one request channel per memory.
    mem_access_if #(.OFFSET_WIDTH(`RAM_OFFSET_WIDTH)) ram_access ();
    mem_access_if #(.OFFSET_WIDTH(`IO_OFFSET_WIDTH))  io_access ();

    // the RAM is read and written over one range.
    memory_addressing #(
        .READ_BASE    (`RAM_BASE),
        .READ_BOUND   (`RAM_BOUND),
        .WRITE_BASE   (`RAM_BASE),
        .WRITE_BOUND  (`RAM_BOUND),
        .OFFSET_WIDTH (`RAM_OFFSET_WIDTH)
    ) u_ram_addressing (
        .ior             (ior),
        .cancel          (cancel),
        .read_addr       (read_addr),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .port            (ram_access.request)
    );

    // the I/O bank reads inputs and writes outputs in two separate ranges.
    memory_addressing #(
        .READ_BASE    (`IO_IN_BASE),
        .READ_BOUND   (`IO_IN_BOUND),
        .WRITE_BASE   (`IO_OUT_BASE),
        .WRITE_BOUND  (`IO_OUT_BOUND),
        .OFFSET_WIDTH (`IO_OFFSET_WIDTH)
    ) u_io_addressing (
        .ior             (ior),
        .cancel          (cancel),
        .read_addr       (read_addr),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .port            (io_access.request)
    );

    data_ram u_data_ram (
        .clock     (clock),
        .port      (ram_access.target),
        .read_word (ram_word)
    );

    io_port_bank u_io_port_bank (
        .clock     (clock),
        .rst       (rst),
        .io_in     (io_in),
        .io_out    (io_out),
        .port      (io_access.target),
        .read_word (io_word)
    );

    // picks the word of whichever target accepted the read.
    read_return u_read_return (
        .clock      (clock),
        .rst        (rst),
        .ram_side   (ram_access.observe),
        .io_side    (io_access.observe),
        .ram_word   (ram_word),
        .io_word    (io_word),
        .read_data  (read_data),
        .read_valid (read_valid)
    );

endmodule

`default_nettype wire

/* verilog/read_return.sv */
//********************
// read data and its strobe arrive exactly one cycle after the read.
// a read that no target accepted returns zero with no strobe.
//********************
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input wire clock,
    input wire rst,

    mem_access_if.observe ram_side,
    mem_access_if.observe io_side,

    input wire mem_map_pkg::data_t ram_word,
    input wire mem_map_pkg::data_t io_word,

    output mem_map_pkg::data_t read_data,
    output logic               read_valid
);

    // bit positions in the one-hot hit record.
    localparam int HIT_RAM = 0;
    localparam int HIT_IO  = 1;

    logic [1:0] hit_q;

    // the ranges do not overlap, so at most one bit is set.
    always_ff @(posedge clock) begin
        if (rst) begin
            hit_q <= '0;
        end else begin
            hit_q <= {io_side.read_enable, ram_side.read_enable};
        end
    end

    assign read_valid = |hit_q;

    // each target holds its word after the read, so a plain select is enough.
    always_comb begin
        if (hit_q[HIT_RAM]) begin
            read_data = ram_word;
        end else if (hit_q[HIT_IO]) begin
            read_data = io_word;
        end else begin
            read_data = '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/io_port_bank.sv */
//********************
// inputs are sampled every cycle, so reads see io_in one cycle old.
// outputs reset to zero and change the cycle after a write.
//********************
`timescale 1ns/1ps
`default_nettype none

module io_port_bank (
    input wire                         clock,
    input wire                         rst,

    input wire mem_map_pkg::io_words_t io_in,
    output mem_map_pkg::io_words_t     io_out,

    mem_access_if.target port,

    output mem_map_pkg::data_t read_word
);

    mem_map_pkg::io_words_t io_in_q;
    mem_map_pkg::io_words_t io_out_q;

    // the external inputs are registered once before any read sees them.
    // this also keeps asynchronous pins off the read path.
    always_ff @(posedge clock) begin
        io_in_q <= io_in;
    end

    // a read in this cycle returns the sample taken at the previous edge.
    always_ff @(posedge clock) begin
        if (port.read_enable) begin
            read_word <= io_in_q[port.read_offset];
        end
    end

    // output registers hold their value until written again.
    always_ff @(posedge clock) begin
        if (rst) begin
            io_out_q <= '0;
        end else if (port.write_enable) begin
            io_out_q[port.write_offset] <= port.write_data;
        end
    end

    assign io_out = io_out_q;

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
//********************
// read-first RAM; contents are not reset.
// read_word holds its value until the next read.
//********************
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module data_ram (
    input wire clock,

    mem_access_if.target port,

    output mem_map_pkg::data_t read_word
);

    // one word per RAM offset.
    localparam int DEPTH = 1 << `RAM_OFFSET_WIDTH;

    mem_map_pkg::data_t mem [DEPTH];

    // the write lands at the edge that ends the strobe cycle.
    always_ff @(posedge clock) begin
        if (port.write_enable) begin
            mem[port.write_offset] <= port.write_data;
        end
    end

    // the read samples the array at the same edge, so a write to the same
    // offset in that cycle is not yet visible and the old word comes back.
    always_ff @(posedge clock) begin
        if (port.read_enable) begin
            read_word <= mem[port.read_offset];
        end
    end

endmodule

`default_nettype wire

/* verilog/memory_addressing.sv */
//********************
// combinational decoder; base and bound are inclusive.
// the read map and the write map are independent of each other.
//********************
`timescale 1ns/1ps
`default_nettype none

module memory_addressing #(
    parameter mem_map_pkg::addr_t READ_BASE    = '0,
    parameter mem_map_pkg::addr_t READ_BOUND   = '0,
    parameter mem_map_pkg::addr_t WRITE_BASE   = '0,
    parameter mem_map_pkg::addr_t WRITE_BOUND  = '0,
    parameter int                 OFFSET_WIDTH = 8
) (
    // from the current instruction, which reads memory.
    input wire                     ior,
    input wire                     cancel,
    input wire mem_map_pkg::addr_t read_addr,

    // from the previous instruction, which is about to write memory.
    input wire                     ior_previous,
    input wire                     cancel_previous,
    input wire mem_map_pkg::addr_t write_addr,
    input wire mem_map_pkg::data_t write_data,

    mem_access_if.request port
);

    logic               read_instruction_ok;
    logic               write_instruction_ok;
    logic               read_hit;
    logic               write_hit;
    mem_map_pkg::addr_t read_delta;
    mem_map_pkg::addr_t write_delta;

    // an access counts only if its instruction was issued and not cancelled.
    assign read_instruction_ok  = ior && !cancel;
    assign write_instruction_ok = ior_previous && !cancel_previous;

    // inclusive range compare on each side.
    assign read_hit  = (read_addr >= READ_BASE) && (read_addr <= READ_BOUND);
    assign write_hit = (write_addr >= WRITE_BASE) && (write_addr <= WRITE_BOUND);

    // an address outside the range gives no strobe and so does nothing.
    assign port.read_enable  = read_instruction_ok && read_hit;
    assign port.write_enable = write_instruction_ok && write_hit;

    // the local offset is the distance from the base.
    // only the low bits matter once the address is known to be in range.
    assign read_delta        = read_addr - READ_BASE;
    assign write_delta       = write_addr - WRITE_BASE;
    assign port.read_offset  = read_delta[OFFSET_WIDTH-1:0];
    assign port.write_offset = write_delta[OFFSET_WIDTH-1:0];

    // the write word is only sampled when write_enable is high.
    assign port.write_data = write_data;

endmodule

`default_nettype wire

/* verilog/mem_access_if.sv */
//********************
// gated request from one decoder to one memory; no ready, no stall.
//********************
`timescale 1ns/1ps
`default_nettype none

interface mem_access_if #(
    parameter int OFFSET_WIDTH = 8
);

    // the read request, a single-cycle strobe with its offset.
    logic                    read_enable;
    logic [OFFSET_WIDTH-1:0] read_offset;

    // the write request, a single-cycle strobe with its offset and word.
    logic                    write_enable;
    logic [OFFSET_WIDTH-1:0] write_offset;
    mem_map_pkg::data_t      write_data;

    // the decoder drives every field.
    modport request (
        output read_enable, read_offset,
        output write_enable, write_offset, write_data
    );

    // the memory only receives.
    modport target (
        input read_enable, read_offset,
        input write_enable, write_offset, write_data
    );

    // the read return only needs to know that a read was accepted.
    modport observe (input read_enable);

endinterface

`default_nettype wire

/* verilog/mem_map_pkg.sv */
//********************
// address and data types shared by the design and its testbench.
//********************
`default_nettype none

`include "mem_config.svh"

package mem_map_pkg;

    // a global word address as the pipeline presents it.
    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

    // one data word.
    typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

    // an offset inside the RAM range.
    typedef logic [`RAM_OFFSET_WIDTH-1:0] ram_offset_t;

    // an offset inside either I/O range.
    typedef logic [`IO_OFFSET_WIDTH-1:0] io_offset_t;

    // the full set of I/O words, one per I/O offset.
    // word 0 sits at the base of its range.
    typedef data_t [(1 << `IO_OFFSET_WIDTH)-1:0] io_words_t;

endpackage

`default_nettype wire

/* verilog/mem_config.svh */
//********************
// widths and inclusive address ranges of the memory subsystem.
// offset widths must cover the largest range that uses them.
//********************
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// a global address selects one word, and a word is 32 bits.
`define MEM_ADDR_WIDTH 10
`define MEM_DATA_WIDTH 32

// the RAM is read and written over the same range.
`define RAM_BASE  10'h000
`define RAM_BOUND 10'h0FF

// the I/O bank reads its inputs and writes its outputs at different addresses.
`define IO_IN_BASE   10'h200
`define IO_IN_BOUND  10'h207
`define IO_OUT_BASE  10'h208
`define IO_OUT_BOUND 10'h20F

// local offsets after the base has been removed.
`define RAM_OFFSET_WIDTH 8
`define IO_OFFSET_WIDTH  3

`endif
